// ==== face_pkg.sv ====
// Shared frame geometry, pixel and score types, window struct and stage tables; imported by every design file
`default_nettype none

package face_pkg;

  // Frame geometry
  localparam int FRAME_WIDTH  = 10;
  localparam int FRAME_HEIGHT = 10;
  localparam int WIN_SIZE     = 3;  // Window edge in pixels
  localparam int STAGE_COUNT  = 3;  // Cascade stages, all run in parallel

  typedef logic        [7:0]             pixel_t;      // Unsigned grayscale pixel
  typedef logic        [3:0]             coord_t;      // Frame coordinate, 0 to 9
  typedef logic signed [11:0]            score_t;      // Weighted window sum
  typedef logic        [6:0]             count_t;      // Faces per frame, at most 64
  typedef logic        [STAGE_COUNT-1:0] stage_mask_t; // One pass bit per stage
  typedef logic signed [1:0]             weight_t;     // Weight of -1, 0 or +1

  // 3 by 3 window; pix[row][col], row 0 is the oldest row, col 0 the leftmost
  typedef struct packed {
    pixel_t [WIN_SIZE-1:0][WIN_SIZE-1:0] pix;
    coord_t                              x;    // Bottom-right pixel column
    coord_t                              y;    // Bottom-right pixel row
    logic                                last; // Window ends at the frame's final pixel
  } window_s;

  // Weights per stage, row-major in the same order as pix (index row*WIN_SIZE+col)
  localparam weight_t STAGE_WEIGHTS [STAGE_COUNT][WIN_SIZE*WIN_SIZE] = '{
    // Horizontal edge, bright top row over dark bottom row
    '{ 2'sd1,  2'sd1,  2'sd1,
       2'sd0,  2'sd0,  2'sd0,
      -2'sd1, -2'sd1, -2'sd1},
    // Vertical edge, bright left column against dark right column
    '{ 2'sd1,  2'sd0, -2'sd1,
       2'sd1,  2'sd0, -2'sd1,
       2'sd1,  2'sd0, -2'sd1},
    // Centre check, corners count up and the centre counts down
    '{ 2'sd1,  2'sd0,  2'sd1,
       2'sd0, -2'sd1,  2'sd0,
       2'sd1,  2'sd0,  2'sd1}
  };

  // Stage passes when its sum is at least this value
  localparam score_t STAGE_THRESHOLDS [STAGE_COUNT] = '{
    12'sd48,  // Horizontal edge
    12'sd48,  // Vertical edge
    12'sd96   // Centre check
  };

endpackage

`default_nettype wire

// ==== window_builder.sv ====
// Raster tracker and two-row line buffer; turns the pixel stream into 3x3 windows with a candidate strobe
`timescale 1ns/100ps
`default_nettype none

module window_builder
  import face_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  pixel_t  pixel,
  input  logic    wen,
  output window_s win,
  output logic    win_valid
);

  coord_t x;                            // Column of the incoming pixel
  coord_t y;                            // Row of the incoming pixel
  pixel_t row1_buf [FRAME_WIDTH];       // Previous row
  pixel_t row2_buf [FRAME_WIDTH];       // Row before that
  logic   at_row_end;
  logic   at_frame_end;
  logic   full_window;

  assign at_row_end   = (x == coord_t'(FRAME_WIDTH - 1));
  assign at_frame_end = at_row_end && (y == coord_t'(FRAME_HEIGHT - 1));
  // A whole 3x3 window exists once two columns and two rows lie behind us
  assign full_window  = (x >= coord_t'(WIN_SIZE - 1)) && (y >= coord_t'(WIN_SIZE - 1));

  // Raster position, moves only on writes
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      x <= '0;
      y <= '0;
    end
    else if (wen)
    begin
      if (at_row_end)
      begin
        x <= '0;
        y <= at_frame_end ? '0 : y + 1'b1; // Wrap to the next frame
      end
      else
        x <= x + 1'b1;
    end
  end

  // Line buffers age one row per write at the current column
  always_ff @(posedge clk)
  begin
    if (wen)
    begin
      row2_buf[x] <= row1_buf[x];
      row1_buf[x] <= pixel;
    end
  end

  // Column shift register; the new column enters on the right
  always_ff @(posedge clk)
  begin
    if (wen)
    begin
      for (int r = 0; r < WIN_SIZE; r++)
      begin
        for (int c = 0; c < WIN_SIZE - 1; c++)
          win.pix[r][c] <= win.pix[r][c + 1];
      end
      win.pix[0][WIN_SIZE-1] <= row2_buf[x]; // Oldest row
      win.pix[1][WIN_SIZE-1] <= row1_buf[x];
      win.pix[2][WIN_SIZE-1] <= pixel;       // Current row
      win.x    <= x;
      win.y    <= y;
      win.last <= at_frame_end;
    end
  end

  // Candidate strobe, one cycle after the completing write
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      win_valid <= 1'b0;
    else
      win_valid <= wen && full_window;
  end

  // Column counter never leaves the row
  a_x_in_row: assert property (@(posedge clk) disable iff (!rst_n)
    x <= coord_t'(FRAME_WIDTH - 1))
    else $error("window_builder: x beyond last column");

endmodule

`default_nettype wire

// ==== stage_classifier.sv ====
// One cascade stage; weights the window by its table row and registers the threshold test every cycle
`timescale 1ns/100ps
`default_nettype none

module stage_classifier
  import face_pkg::*;
#(
  parameter int STAGE_ID = 0  // Row of STAGE_WEIGHTS and STAGE_THRESHOLDS
)
(
  input  logic    clk,
  input  window_s win,
  output logic    pass
);

  score_t sum;  // Signed weighted sum of the nine pixels

  // Weights are only -1, 0 or +1 so add or subtract, no multiplier
  always_comb
  begin
    sum = '0;
    for (int r = 0; r < WIN_SIZE; r++)
    begin
      for (int c = 0; c < WIN_SIZE; c++)
      begin
        if (STAGE_WEIGHTS[STAGE_ID][r*WIN_SIZE + c] == 2'sd1)
          sum = sum + score_t'(win.pix[r][c]);   // Zero-extended pixel
        else if (STAGE_WEIGHTS[STAGE_ID][r*WIN_SIZE + c] == -2'sd1)
          sum = sum - score_t'(win.pix[r][c]);
      end
    end
  end

  // Free-running compare, the decision block picks the valid cycle
  always_ff @(posedge clk)
  begin
    pass <= (sum >= STAGE_THRESHOLDS[STAGE_ID]);
  end

  // Table row must exist
  a_stage_id: assert property (@(posedge clk) STAGE_ID < STAGE_COUNT)
    else $error("stage_classifier: STAGE_ID %0d out of range", STAGE_ID);

endmodule

`default_nettype wire

// ==== cascade_decision.sv ====
// Cascade decision; aligns window position with the stage results, flags faces and counts them per frame
`timescale 1ns/100ps
`default_nettype none

module cascade_decision
  import face_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  window_s     win,
  input  logic        win_valid,
  input  stage_mask_t stage_pass,
  output logic        face,
  output coord_t      face_x,
  output coord_t      face_y,
  output logic        frame_done,
  output count_t      frame_faces
);

  logic   valid_d;   // win_valid lined up with stage_pass
  logic   last_d;    // Final window of the frame, same alignment
  coord_t x_d;
  coord_t y_d;
  count_t running;   // Faces seen so far in this frame
  logic   face_hit;

  assign face_hit = valid_d && (&stage_pass); // Every stage must pass

  // Strobes delayed by one cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_d <= 1'b0;
      last_d  <= 1'b0;
    end
    else
    begin
      valid_d <= win_valid;
      last_d  <= win_valid && win.last; // last is held between writes, so qualify it
    end
  end

  // Window position follows its candidate
  always_ff @(posedge clk)
  begin
    if (win_valid)
    begin
      x_d <= win.x;
      y_d <= win.y;
    end
    if (valid_d)
    begin
      face_x <= x_d;  // Holds the last tested window
      face_y <= y_d;
    end
  end

  // Face pulse, per-frame count and frame end
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      face        <= 1'b0;
      frame_done  <= 1'b0;
      frame_faces <= '0;
      running     <= '0;
    end
    else
    begin
      face       <= face_hit;
      frame_done <= last_d;
      if (last_d)
      begin
        frame_faces <= running + count_t'(face_hit); // Include the final window
        running     <= '0;
      end
      else if (face_hit)
        running <= running + 1'b1;
    end
  end

  // End of frame is always reported at the bottom-right corner
  a_done_at_corner: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |-> (face_x == coord_t'(FRAME_WIDTH - 1)) &&
                   (face_y == coord_t'(FRAME_HEIGHT - 1)))
    else $error("cascade_decision: frame_done away from frame corner");

endmodule

`default_nettype wire

// ==== face_detect_top.sv ====
// Face detector front end; window builder feeding parallel cascade stages and the decision block
`timescale 1ns/100ps
`default_nettype none

module face_detect_top
  import face_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  pixel_t pixel,
  input  logic   wen,         // One pixel per strobe, raster order
  output logic   face,        // Pulse per face window
  output coord_t face_x,
  output coord_t face_y,
  output logic   frame_done,  // Pulse after the frame's last window
  output count_t frame_faces  // Held until the next frame_done
);

  window_s     win;
  logic        win_valid;
  stage_mask_t stage_pass;

  window_builder u_window_builder (
    .clk       (clk),
    .rst_n     (rst_n),
    .pixel     (pixel),
    .wen       (wen),
    .win       (win),
    .win_valid (win_valid)
  );

  // One classifier per cascade stage, all see the same window
  for (genvar g = 0; g < STAGE_COUNT; g++)
  begin : g_stage
    stage_classifier #(
      .STAGE_ID (g)
    ) u_stage_classifier (
      .clk  (clk),
      .win  (win),
      .pass (stage_pass[g])
    );
  end

  cascade_decision u_cascade_decision (
    .clk         (clk),
    .rst_n       (rst_n),
    .win         (win),
    .win_valid   (win_valid),
    .stage_pass  (stage_pass),
    .face        (face),
    .face_x      (face_x),
    .face_y      (face_y),
    .frame_done  (frame_done),
    .frame_faces (frame_faces)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source; free-running 8 ns clock, reset held low for the first 16 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
  output logic clk,
  output logic rst_n
);

  localparam real HALF_PERIOD_NS = 4.0;  // 8 ns period
  localparam int  RESET_CYCLES   = 16;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);  // Release on a falling edge, like the other inputs
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_face_detect.sv ====
// Face detector testbench; streams five frames, predicts faces from the stage tables, checks by assertions
`timescale 1ns/100ps
`default_nettype none

module tb_face_detect
  import face_pkg::*;
();

  localparam int  FRAME_PIXELS  = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int  FRAME_COUNT   = 5;     // Three random, one planted, one flat
  localparam int  PIPE_DELAY    = 3;     // Write to face, in cycles
  localparam int  MAX_GAP       = 2;     // Idle cycles after a random write, at most
  localparam int  SCHED_DEPTH   = 2048;  // Expected-value slots, one per clock
  localparam real CLK_PERIOD_NS = 8.0;
  localparam real WATCHDOG_NS   = FRAME_COUNT * FRAME_PIXELS * 3 * CLK_PERIOD_NS + 2000.0;
  localparam logic [31:0] RANDOM_SEED = 32'h4b706cbf;

  logic   clk;
  logic   rst_n;
  pixel_t pixel;
  logic   wen;
  logic   face;
  coord_t face_x;
  coord_t face_y;
  logic   frame_done;
  count_t frame_faces;

  // Expected outputs, indexed by the clock in which they should be visible
  logic   sched_face  [SCHED_DEPTH];
  coord_t sched_x     [SCHED_DEPTH];
  coord_t sched_y     [SCHED_DEPTH];
  logic   sched_done  [SCHED_DEPTH];
  count_t sched_count [SCHED_DEPTH];

  logic   exp_face;           // Expected outputs for the current clock
  coord_t exp_x;
  coord_t exp_y;
  logic   exp_done;
  count_t exp_count;          // Held like frame_faces

  pixel_t frame_img [FRAME_HEIGHT][FRAME_WIDTH];  // Model copy of the frame being written
  int     model_x = 0;
  int     model_y = 0;
  count_t model_count = '0;   // Faces predicted so far in this frame
  int     model_faces_total = 0;
  count_t frame_totals [FRAME_COUNT];
  int     frame_index = 0;

  int cyc            = 0;     // Rising edges since time zero
  int mismatch_count = 0;
  int other_errors   = 0;
  int faces_seen     = 0;
  int frames_seen    = 0;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  face_detect_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixel       (pixel),
    .wen         (wen),
    .face        (face),
    .face_x      (face_x),
    .face_y      (face_y),
    .frame_done  (frame_done),
    .frame_faces (frame_faces)
  );

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (rst_n && face)
      faces_seen++;
    if (rst_n && frame_done)
      frames_seen++;
  end

  // Load this clock's expectations on the falling edge, stable for the next rising edge
  always @(negedge clk)
  begin
    if (cyc < SCHED_DEPTH)
    begin
      exp_face = sched_face[cyc];
      exp_x    = sched_x[cyc];
      exp_y    = sched_y[cyc];
      exp_done = sched_done[cyc];
      if (sched_done[cyc])
        exp_count = sched_count[cyc];
    end
  end

  task automatic report_mismatch(input string name, input int got, input int want);
    mismatch_count++;
    $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
  endtask

  a_face: assert property (@(posedge clk) disable iff (!rst_n) face == exp_face)
    else report_mismatch("face", $sampled(face), exp_face);

  a_face_x: assert property (@(posedge clk) disable iff (!rst_n) exp_face |-> face_x == exp_x)
    else report_mismatch("face_x", $sampled(face_x), exp_x);

  a_face_y: assert property (@(posedge clk) disable iff (!rst_n) exp_face |-> face_y == exp_y)
    else report_mismatch("face_y", $sampled(face_y), exp_y);

  a_frame_done: assert property (@(posedge clk) disable iff (!rst_n) frame_done == exp_done)
    else report_mismatch("frame_done", $sampled(frame_done), exp_done);

  a_frame_faces: assert property (@(posedge clk) disable iff (!rst_n)
    frame_faces == exp_count)
    else report_mismatch("frame_faces", $sampled(frame_faces), exp_count);

  // Weighted sum of one stage over the window ending at bx, by
  function automatic logic stage_passes(input int stage, input int bx, input int by);
    int acc;
    int w;
    int px;
    acc = 0;
    for (int r = 0; r < WIN_SIZE; r++)
    begin
      for (int c = 0; c < WIN_SIZE; c++)
      begin
        w   = int'(STAGE_WEIGHTS[stage][r*WIN_SIZE + c]);   // Sign-extended weight
        px  = int'(frame_img[by - (WIN_SIZE - 1) + r][bx - (WIN_SIZE - 1) + c]);
        acc = acc + w * px;
      end
    end
    return acc >= int'(STAGE_THRESHOLDS[stage]);
  endfunction

  function automatic logic window_passes(input int bx, input int by);
    logic all_pass;
    all_pass = 1'b1;
    for (int s = 0; s < STAGE_COUNT; s++)
      all_pass = all_pass & stage_passes(s, bx, by);
    return all_pass;
  endfunction

  // One write on the next rising edge, with its predicted outcome scheduled
  task automatic write_pixel(input pixel_t value);
    int slot;
    slot  = cyc + PIPE_DELAY;  // Clock in which face shows up
    pixel = value;
    wen   = 1'b1;
    frame_img[model_y][model_x] = value;
    if (slot >= SCHED_DEPTH)
    begin
      other_errors++;
      $display("Run longer than the expectation table at %0t", $time);
    end
    else
    begin
      if (model_x >= WIN_SIZE - 1 && model_y >= WIN_SIZE - 1 && window_passes(model_x, model_y))
      begin
        sched_face[slot] = 1'b1;
        sched_x[slot]    = coord_t'(model_x);
        sched_y[slot]    = coord_t'(model_y);
        model_count      = model_count + 1'b1;
        model_faces_total++;
      end
      if (model_x == FRAME_WIDTH - 1 && model_y == FRAME_HEIGHT - 1)
      begin
        sched_done[slot]  = 1'b1;
        sched_count[slot] = model_count;  // Includes the final window
        frame_totals[frame_index] = model_count;
        frame_index++;
        model_count = '0;
      end
    end
    // Raster position, wraps at row and frame end
    if (model_x == FRAME_WIDTH - 1)
    begin
      model_x = 0;
      model_y = (model_y == FRAME_HEIGHT - 1) ? 0 : model_y + 1;
    end
    else
      model_x++;
    @(negedge clk);
    wen = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    wen = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic send_random_frame();
    for (int i = 0; i < FRAME_PIXELS; i++)
    begin
      write_pixel(pixel_t'($urandom));
      if ($urandom_range(0, 1) == 1)
        idle_cycles($urandom_range(1, MAX_GAP));  // Gap in wen
    end
  endtask

  // Gradient falling to the right and downward, every window passes all stages
  task automatic send_planted_frame();
    for (int y = 0; y < FRAME_HEIGHT; y++)
    begin
      for (int x = 0; x < FRAME_WIDTH; x++)
        write_pixel(pixel_t'(255 - 10 * x - 10 * y));
    end
  endtask

  task automatic send_flat_frame();
    for (int i = 0; i < FRAME_PIXELS; i++)
      write_pixel(8'd128);  // No edges, no centre contrast
  endtask

  initial
  begin
    pixel     = '0;
    wen       = 1'b0;
    exp_face  = 1'b0;
    exp_x     = '0;
    exp_y     = '0;
    exp_done  = 1'b0;
    exp_count = '0;
    for (int i = 0; i < SCHED_DEPTH; i++)
    begin
      sched_face[i]  = 1'b0;
      sched_x[i]     = '0;
      sched_y[i]     = '0;
      sched_done[i]  = 1'b0;
      sched_count[i] = '0;
    end
    void'($urandom(RANDOM_SEED));

    wait (rst_n === 1'b1);
    @(negedge clk);
    idle_cycles(4);  // Outputs must stay quiet after reset

    // Frames follow each other with no gap, across the wrap
    send_random_frame();
    send_random_frame();
    send_random_frame();
    send_planted_frame();
    send_flat_frame();
    wen = 1'b0;

    while (frames_seen < FRAME_COUNT)
      @(negedge clk);  // Watchdog bounds this wait
    idle_cycles(4);

    a_frame_total: assert (frames_seen == FRAME_COUNT)
      else
      begin
        other_errors++;
        $display("Saw %0d frame_done pulses instead of %0d", frames_seen, FRAME_COUNT);
      end
    a_face_total: assert (faces_seen == model_faces_total)
      else
      begin
        other_errors++;
        $display("Saw %0d faces in total, the model predicts %0d", faces_seen, model_faces_total);
      end
    a_planted_total: assert (frame_totals[3] == count_t'(64))
      else
      begin
        other_errors++;
        $display("Planted frame predicts %0d faces instead of 64", frame_totals[3]);
      end
    a_flat_total: assert (frame_totals[4] == count_t'(0))
      else
      begin
        other_errors++;
        $display("Flat frame predicts %0d faces instead of none", frame_totals[4]);
      end

    $display("Summary: %0d frames, %0d faces, %0d mismatches, %0d other errors",
             frames_seen, faces_seen, mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Five frames at up to three clocks per pixel, plus reset and drain
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t before the last frame completed", $time);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
face_pkg.sv
window_builder.sv
stage_classifier.sv
cascade_decision.sv
face_detect_top.sv
tb_clock_gen.sv
tb_face_detect.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the face detector testbench with Verilator, run it, judge the run from its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_face_detect -f vlog.f -o sim_face_detect &&
./obj_dir/sim_face_detect | tee /dev/stderr | grep -q "^All tests passed$" &&
echo "Simulation run OK" ||
{
  echo "Simulation run FAILED"
  exit 1
}
